//--- hw/capture_addr_counter.sv
// Capture write address generator
// Steps through every address once per capture and flags the last one

`timescale 1ns/10ps

module capture_addr_counter
    import pktctrl_ctrl_pkg::*;
#(
    parameter int ADDR_W = 6
) (
    input  logic              pktctrl_clk,
    input  logic              pktctrl_rstn,
    input  mem_ctrl_t         mem_ctrl,
    output logic [ADDR_W-1:0] waddr,
    output logic              wr_done
);

    // Held at zero outside a capture
    always_ff @(posedge pktctrl_clk or negedge pktctrl_rstn) begin
        if (!pktctrl_rstn) begin
            waddr <= '0;
        end else if (mem_ctrl.write_en) begin
            waddr <= waddr + 1'b1;
        end else begin
            waddr <= '0;
        end
    end

    assign wr_done = mem_ctrl.write_en && (waddr == {ADDR_W{1'b1}});

    // FSM leaves write on the edge after the last address
    a_done_ends_write : assert property (
        @(posedge pktctrl_clk) disable iff (!pktctrl_rstn)
        wr_done |=> !mem_ctrl.write_en
    );

endmodule

//--- hw/capture_fsm.sv
// Capture FSM
// Sequences idle, write and read, decodes memory control from the state

`timescale 1ns/10ps

module capture_fsm
    import pktctrl_ctrl_pkg::*;
(
    input  logic      pktctrl_clk,
    input  logic      pktctrl_rstn,
    input  logic      rf_capture_start,
    input  logic      wr_done,
    output mem_ctrl_t mem_ctrl,
    output logic      capture_busy
);

    cap_state_e state;
    cap_state_e next_state;

    // --------------------------------------------------
    // State register
    // --------------------------------------------------
    always_ff @(posedge pktctrl_clk or negedge pktctrl_rstn) begin
        if (!pktctrl_rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (rf_capture_start) begin
                    next_state = WRITE;
                end
            end
            // Start requests are ignored until the last address is written
            WRITE: begin
                if (wr_done) begin
                    next_state = READ;
                end
            end
            READ: begin
                if (rf_capture_start) begin
                    next_state = WRITE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Outputs from state only
    assign mem_ctrl.write_en = (state == WRITE);
    assign mem_ctrl.read_en  = (state == READ);
    assign capture_busy      = (state == WRITE);

    a_state_onehot : assert property (
        @(posedge pktctrl_clk) disable iff (!pktctrl_rstn)
        $onehot(state)
    );

endmodule

//--- hw/mdio_slice_reader.sv
// Register slice read path
// Picks one 9-bit slice of one bank word by data-select code

`timescale 1ns/10ps

module mdio_slice_reader
    import pktctrl_ctrl_pkg::*;
    import pktctrl_data_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic                        pktctrl_clk,
    input  logic                        pktctrl_rstn,
    input  mem_ctrl_t                   mem_ctrl,
    input  logic      [MAX_SEL_W-1:0]   data_sel,
    input  pkt_word_u [NUM_BANKS-1:0]   bank_dout,
    output pkt_slice_t                  rf_mdio_pkt_data
);

    localparam int IDX_W     = $clog2(SLICES_PER_WORD);
    localparam int NUM_CODES = NUM_BANKS * SLICES_PER_WORD;

    logic [MAX_SEL_W-IDX_W-1:0] bank_idx;
    logic [IDX_W-1:0]           slice_idx;
    pkt_word_u                  sel_word;
    pkt_slice_t                 slice_next;

    // Code is bank times four plus slice
    assign bank_idx  = data_sel[MAX_SEL_W-1:IDX_W];
    assign slice_idx = data_sel[IDX_W-1:0];

    // --------------------------------------------------
    // Bank and slice select
    // --------------------------------------------------
    always_comb begin
        sel_word = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_idx == b) begin
                sel_word = bank_dout[b];
            end
        end
        // Codes past the last bank read as zero
        if (data_sel < NUM_CODES) begin
            slice_next = sel_word.slice[slice_idx];
        end else begin
            slice_next = '0;
        end
    end

    // Output register, holds outside the read state
    always_ff @(posedge pktctrl_clk or negedge pktctrl_rstn) begin
        if (!pktctrl_rstn) begin
            rf_mdio_pkt_data <= '0;
        end else if (mem_ctrl.read_en) begin
            rf_mdio_pkt_data <= slice_next;
        end
    end

endmodule

//--- hw/package_ctrl.sv
// Packet capture controller top level
// Fills the sample banks on a start pulse and serves register slice reads

`timescale 1ns/10ps

module package_ctrl
    import pktctrl_ctrl_pkg::*;
    import pktctrl_data_pkg::*;
#(
    parameter int NUM_BANKS = 4,
    parameter int ADDR_W    = 6
) (
    input  logic                        pktctrl_clk,
    input  logic                        pktctrl_rstn,
    input  logic                        rf_capture_start,
    input  pkt_word_u [NUM_BANKS-1:0]   adc_data,
    input  mdio_req_t                   mdio_req,
    output pkt_slice_t                  rf_mdio_pkt_data,
    output logic                        capture_busy
);

    mem_ctrl_t                  mem_ctrl;
    logic      [ADDR_W-1:0]     waddr;
    logic                       wr_done;
    logic      [ADDR_W-1:0]     raddr;
    pkt_word_u [NUM_BANKS-1:0]  bank_dout;

    // Only the low address bits reach the banks
    assign raddr = mdio_req.memory_addr[ADDR_W-1:0];

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    capture_fsm u_capture_fsm (
        .pktctrl_clk      (pktctrl_clk),
        .pktctrl_rstn     (pktctrl_rstn),
        .rf_capture_start (rf_capture_start),
        .wr_done          (wr_done),
        .mem_ctrl         (mem_ctrl),
        .capture_busy     (capture_busy)
    );

    capture_addr_counter #(
        .ADDR_W (ADDR_W)
    ) u_capture_addr_counter (
        .pktctrl_clk  (pktctrl_clk),
        .pktctrl_rstn (pktctrl_rstn),
        .mem_ctrl     (mem_ctrl),
        .waddr        (waddr),
        .wr_done      (wr_done)
    );

    // --------------------------------------------------
    // Storage and read path
    // --------------------------------------------------
    sample_bank_array #(
        .NUM_BANKS (NUM_BANKS),
        .ADDR_W    (ADDR_W)
    ) u_sample_bank_array (
        .pktctrl_clk (pktctrl_clk),
        .mem_ctrl    (mem_ctrl),
        .waddr       (waddr),
        .raddr       (raddr),
        .adc_data    (adc_data),
        .bank_dout   (bank_dout)
    );

    mdio_slice_reader #(
        .NUM_BANKS (NUM_BANKS)
    ) u_mdio_slice_reader (
        .pktctrl_clk      (pktctrl_clk),
        .pktctrl_rstn     (pktctrl_rstn),
        .mem_ctrl         (mem_ctrl),
        .data_sel         (mdio_req.data_sel),
        .bank_dout        (bank_dout),
        .rf_mdio_pkt_data (rf_mdio_pkt_data)
    );

endmodule

//--- hw/pktctrl_ctrl_pkg.sv
// Packet capture control definitions
// State encoding, memory control bits and the register read request

package pktctrl_ctrl_pkg;

    // Register request field widths
    localparam int MAX_ADDR_W = 15;
    localparam int MAX_SEL_W  = 7;

    // One-hot capture state
    typedef enum logic [2:0] {
        IDLE  = 3'b001,
        WRITE = 3'b010,
        READ  = 3'b100
    } cap_state_e;

    // Memory control, decoded from the FSM state
    typedef struct packed {
        logic write_en;
        logic read_en;
    } mem_ctrl_t;

    // Register interface read request
    typedef struct packed {
        logic [MAX_SEL_W-1:0]  data_sel;
        logic [MAX_ADDR_W-1:0] memory_addr;
    } mdio_req_t;

endpackage

//--- hw/pktctrl_data_pkg.sv
// Packet capture data definitions
// ADC samples, register slices and the shared 36-bit memory word

package pktctrl_data_pkg;

    localparam int SAMPLE_W        = 18;
    localparam int SLICE_W         = 9;
    localparam int SLICES_PER_WORD = 4;

    // One ADC sample
    typedef logic [SAMPLE_W-1:0] adc_sample_t;

    // Two samples per memory word on the write side
    typedef struct packed {
        adc_sample_t hi;
        adc_sample_t lo;
    } adc_pair_t;

    // One register-readable slice
    typedef logic [SLICE_W-1:0] pkt_slice_t;

    // --------------------------------------------------
    // Memory word, written as a sample pair and read
    // back as four slices, slice 0 in the low bits
    // --------------------------------------------------
    typedef union packed {
        adc_pair_t                           pair;
        pkt_slice_t [SLICES_PER_WORD-1:0]    slice;
    } pkt_word_u;

endpackage

//--- hw/sample_bank_array.sv
// Sample bank array
// NUM_BANKS single-port memories on one shared address, registered read

`timescale 1ns/10ps

module sample_bank_array
    import pktctrl_ctrl_pkg::*;
    import pktctrl_data_pkg::*;
#(
    parameter int NUM_BANKS = 4,
    parameter int ADDR_W    = 6
) (
    input  logic                            pktctrl_clk,
    input  mem_ctrl_t                       mem_ctrl,
    input  logic      [ADDR_W-1:0]          waddr,
    input  logic      [ADDR_W-1:0]          raddr,
    input  pkt_word_u [NUM_BANKS-1:0]       adc_data,
    output pkt_word_u [NUM_BANKS-1:0]       bank_dout
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [ADDR_W-1:0] mem_addr;

    // --------------------------------------------------
    // Shared address path
    // --------------------------------------------------
    assign mem_addr = mem_ctrl.write_en ? waddr : raddr;

    // --------------------------------------------------
    // Banks, all written together during a capture
    // --------------------------------------------------
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        pkt_word_u mem [DEPTH];
        pkt_word_u dout_q;

        always_ff @(posedge pktctrl_clk) begin
            if (mem_ctrl.write_en) begin
                mem[mem_addr] <= adc_data[b];
            end else if (mem_ctrl.read_en) begin
                dout_q <= mem[mem_addr];
            end
        end

        assign bank_dout[b] = dout_q;
    end

    // Single port, so the FSM must never ask for both
    a_no_rw_overlap : assert property (
        @(posedge pktctrl_clk)
        !(mem_ctrl.write_en && mem_ctrl.read_en)
    );

endmodule

//--- list.f
hw/pktctrl_ctrl_pkg.sv
hw/pktctrl_data_pkg.sv
hw/capture_fsm.sv
hw/capture_addr_counter.sv
hw/sample_bank_array.sv
hw/mdio_slice_reader.sv
hw/package_ctrl.sv
sim/pktctrl_clk_gen.sv
sim/tb_package_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the package_ctrl testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_package_ctrl \
    -f list.f \
    -o tb_package_ctrl

sim_out=$(./obj_dir/tb_package_ctrl)
echo "$sim_out"

if echo "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

//--- sim/pktctrl_clk_gen.sv
// Testbench clock and reset generator
// 40 ns clock, active-low reset held for the first 8 rising edges

`timescale 1ns/10ps

module pktctrl_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic pktctrl_clk,
    output logic pktctrl_rstn
);

    initial begin
        pktctrl_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) pktctrl_clk = ~pktctrl_clk;
        end
    end

    // Release just after an edge, clear of the DUT's sampling point
    initial begin
        pktctrl_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge pktctrl_clk);
        #2;
        pktctrl_rstn = 1'b1;
    end

endmodule

//--- sim/tb_package_ctrl.sv
// Packet capture controller testbench
// Runs two captures of random ADC words and checks table-driven slice reads

`timescale 1ns/10ps

module tb_package_ctrl
    import pktctrl_ctrl_pkg::*;
    import pktctrl_data_pkg::*;
;

    localparam int NUM_BANKS    = 4;
    localparam int ADDR_W       = 6;
    localparam int DEPTH        = 1 << ADDR_W;
    localparam int RESET_CYCLES = 8;
    localparam int HOLD_CYCLES  = 4;
    localparam int NUM_READS    = 12;

    // Run limit of twice the expected test length
    localparam int CAPTURE_LEN    = DEPTH + 2;
    localparam int READ_LEN       = NUM_READS * HOLD_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 2 * CAPTURE_LEN + 2 * READ_LEN + 4);

    // --------------------------------------------------
    // Read table of out-of-range flag, data_sel and memory_addr
    // --------------------------------------------------
    localparam logic [22:0] READ_TABLE [NUM_READS] = '{
        {1'b0, 7'd0,   15'd0},
        {1'b0, 7'd1,   15'd1},
        {1'b0, 7'd2,   15'd2},
        {1'b0, 7'd3,   15'd63},
        {1'b0, 7'd4,   15'd10},
        {1'b0, 7'd7,   15'd33},
        {1'b0, 7'd9,   15'd17},
        {1'b0, 7'd14,  15'd48},
        {1'b0, 7'd15,  15'h7fc5},
        {1'b1, 7'd16,  15'd5},
        {1'b1, 7'd100, 15'd20},
        {1'b1, 7'd127, 15'd63}
    };

    logic                      pktctrl_clk;
    logic                      pktctrl_rstn;
    logic                      rf_capture_start;
    pkt_word_u [NUM_BANKS-1:0] adc_data;
    mdio_req_t                 mdio_req;
    pkt_slice_t                rf_mdio_pkt_data;
    logic                      capture_busy;

    logic [35:0]       ref_mem [NUM_BANKS][DEPTH];
    logic [ADDR_W-1:0] widx = '0;
    integer            seed = 19;
    int                error_count = 0;
    int                check_count = 0;
    int                cycle_count = 0;

    pktctrl_clk_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk_gen (
        .pktctrl_clk  (pktctrl_clk),
        .pktctrl_rstn (pktctrl_rstn)
    );

    package_ctrl u_dut (
        .pktctrl_clk      (pktctrl_clk),
        .pktctrl_rstn     (pktctrl_rstn),
        .rf_capture_start (rf_capture_start),
        .adc_data         (adc_data),
        .mdio_req         (mdio_req),
        .rf_mdio_pkt_data (rf_mdio_pkt_data),
        .capture_busy     (capture_busy)
    );

    task automatic report_mismatch(input string name, input logic [35:0] exp,
                                   input logic [35:0] got);
        error_count++;
        $display("FAILED at %0d ns: %s expected %0h, got %0h", $time, name, exp, got);
    endtask

    task automatic fill_adc_words();
        logic [31:0] rnd_hi;
        logic [31:0] rnd_lo;
        for (int b = 0; b < NUM_BANKS; b++) begin
            rnd_hi = $random(seed);
            rnd_lo = $random(seed);
            adc_data[b].pair.hi = rnd_hi[SAMPLE_W-1:0];
            adc_data[b].pair.lo = rnd_lo[SAMPLE_W-1:0];
        end
    endtask

    // New ADC words every cycle
    initial begin
        adc_data = '0;
        forever begin
            @(posedge pktctrl_clk);
            #2;
            fill_adc_words();
        end
    end

    // Words seen at the mid-cycle point are the ones written on the next edge
    always @(negedge pktctrl_clk) begin
        if (capture_busy) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                ref_mem[b][widx] = adc_data[b];
            end
            widx = widx + 1'b1;
        end else begin
            widx = '0;
        end
    end

    // --------------------------------------------------
    // Capture and read sequences
    // --------------------------------------------------
    task automatic run_capture();
        int busy_cycles;
        busy_cycles = 0;
        rf_capture_start = 1'b1;
        @(posedge pktctrl_clk);
        #2;
        rf_capture_start = 1'b0;
        while (capture_busy) begin
            busy_cycles++;
            @(posedge pktctrl_clk);
            #2;
        end
        check_count++;
        if (busy_cycles != DEPTH) begin
            report_mismatch("capture_busy cycles", 36'(DEPTH), 36'(busy_cycles));
        end
    endtask

    task automatic apply_read_table();
        logic [22:0] entry;
        logic [6:0]  sel;
        logic [14:0] addr;
        logic [35:0] word;
        logic [8:0]  exp;
        for (int i = 0; i < NUM_READS; i++) begin
            entry = READ_TABLE[i];
            sel   = entry[21:15];
            addr  = entry[14:0];
            mdio_req.data_sel    = sel;
            mdio_req.memory_addr = addr;
            repeat (HOLD_CYCLES) @(posedge pktctrl_clk);
            #2;
            if (entry[22]) begin
                exp = '0;
            end else begin
                // Bank is code div 4, slice is code mod 4 with slice 0 lowest
                word = ref_mem[sel / 4][addr[ADDR_W-1:0]];
                exp  = word[sel[1:0] * SLICE_W +: SLICE_W];
            end
            check_count++;
            if (rf_mdio_pkt_data !== exp) begin
                report_mismatch("rf_mdio_pkt_data", 36'(exp), 36'(rf_mdio_pkt_data));
            end
            check_count++;
            if (capture_busy !== 1'b0) begin
                report_mismatch("capture_busy", 36'(0), 36'(capture_busy));
            end
        end
    endtask

    initial begin
        rf_capture_start = 1'b0;
        mdio_req         = '0;
        @(posedge pktctrl_rstn);
        @(posedge pktctrl_clk);
        #2;

        check_count++;
        if (capture_busy !== 1'b0) begin
            report_mismatch("capture_busy", 36'(0), 36'(capture_busy));
        end
        check_count++;
        if (rf_mdio_pkt_data !== '0) begin
            report_mismatch("rf_mdio_pkt_data", 36'(0), 36'(rf_mdio_pkt_data));
        end

        run_capture();
        apply_read_table();

        // Second capture straight from the read state
        run_capture();
        apply_read_table();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    always @(posedge pktctrl_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule
